// File: verilog/tts_cfg.svh
/* raster constants assume a 640x480 mode with the clock running at the pixel rate;
   tile grid is 16x12 tiles of 40 screen pixels */
`ifndef TTS_CFG_SVH
`define TTS_CFG_SVH

// horizontal raster, in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800

// vertical raster, in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

// each sprite pixel covers 5x5 screen pixels
`define UPSCALE 5
`define TILE_PIX 8
`define TILE_LEN (`TILE_PIX * `UPSCALE)

// entity slots, the last two drawn upside down
`define ENTITY_SLOTS 9
`define FLIP_FIRST 8

// id marking an unused slot
`define ID_UNUSED 4'hF

// code shown when no entity covers the pixel
`define CODE_NONE 9'h1FF

`endif

// File: verilog/tts_pkg.sv
/* entity word layout: id[13:10], orientation[9:8], tile row[7:4], tile column[3:0] */
package tts_pkg;

    // host entity word, id 15 marks the slot unused
    typedef logic [13:0] entity_t;

    // pixel counter value, wide enough for the 800 clock line
    typedef logic [9:0] coord_t;

    // slot index, 0..8 stand for entities 1..9
    typedef logic [3:0] slot_t;

    // {sprite row[8:6], id[5:2], orientation[1:0]}, all ones when empty
    typedef logic [8:0] entity_code_t;

    // frame controller states
    typedef enum logic [1:0] {
        ST_WAIT,
        ST_DRAW,
        ST_COMMIT
    } frame_state_t;

endpackage

// File: verilog/scan_timer.sv
/* counters start at 0,0 on the first cycle after reset; sync levels are active low
   and all decoded outputs are registered in step with the counts */
`include "tts_cfg.svh"

module scan_timer import tts_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    output coord_t h_count,
    output coord_t v_count,
    output logic   hsync,
    output logic   vsync,
    output logic   active,
    output logic   vblank_start
);

    localparam coord_t H_LAST = coord_t'(`H_TOTAL - 1);
    localparam coord_t V_LAST = coord_t'(`V_TOTAL - 1);
    // sync windows, first line/pixel in and first one out
    localparam coord_t HS_START = coord_t'(`H_ACTIVE + `H_FRONT);
    localparam coord_t HS_END = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam coord_t VS_START = coord_t'(`V_ACTIVE + `V_FRONT);
    localparam coord_t VS_END = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    coord_t h_next;
    coord_t v_next;

    // line counter carries into the frame counter at end of line
    always_comb begin
        h_next = h_count + coord_t'(1);
        v_next = v_count;
        if (h_count == H_LAST) begin
            h_next = '0;
            if (v_count == V_LAST) begin
                v_next = '0;
            end else begin
                v_next = v_count + coord_t'(1);
            end
        end
    end

    // decode from the next counts so the registered flags match the counts
    always_ff @(posedge clk) begin
        if (rst) begin
            h_count <= '0;
            v_count <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            // 0,0 lies in the visible area
            active <= 1'b1;
            vblank_start <= 1'b0;
        end else begin
            h_count <= h_next;
            v_count <= v_next;
            hsync <= !(h_next >= HS_START && h_next < HS_END);
            vsync <= !(v_next >= VS_START && v_next < VS_END);
            active <= (h_next < coord_t'(`H_ACTIVE)) && (v_next < coord_t'(`V_ACTIVE));
            // first clock of the first blank line
            vblank_start <= (h_next == '0) && (v_next == coord_t'(`V_ACTIVE));
        end
    end

endmodule

// File: verilog/frame_ctrl.sv
/* display stays dark until the first commit; commit fires one cycle after each
   vblank_start, so the live table only changes during blanking */
module frame_ctrl import tts_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic vblank_start,
    output logic commit,
    output logic display_en
);

    frame_state_t state;
    frame_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            // nothing shown until a whole table has been copied
            ST_WAIT: begin
                if (vblank_start) begin
                    state_next = ST_COMMIT;
                end
            end
            // single cycle, then back to drawing
            ST_COMMIT: begin
                state_next = ST_DRAW;
            end
            ST_DRAW: begin
                if (vblank_start) begin
                    state_next = ST_COMMIT;
                end
            end
            default: begin
                state_next = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_WAIT;
            display_en <= 1'b0;
        end else begin
            state <= state_next;
            // latches on after the first commit and stays on
            if (state == ST_COMMIT) begin
                display_en <= 1'b1;
            end
        end
    end

    // one pulse per pass through the commit state
    assign commit = (state == ST_COMMIT);

endmodule

// File: verilog/entity_table.sv
/* writes to slots 9..15 are dropped; a write on a commit edge lands in the shadow
   table only and reaches the live table at the following commit */
`include "tts_cfg.svh"

module entity_table import tts_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    wr_en,
    input  logic    commit,
    input  slot_t   wr_slot,
    input  entity_t wr_entity,
    output entity_t live_1,
    output entity_t live_2,
    output entity_t live_3,
    output entity_t live_4,
    output entity_t live_5,
    output entity_t live_6,
    output entity_t live_7,
    output entity_t live_8,
    output entity_t live_9
);

    // unused id with zero orientation and location
    localparam entity_t ENTITY_EMPTY = {`ID_UNUSED, 10'd0};

    entity_t shadow [`ENTITY_SLOTS];
    entity_t live [`ENTITY_SLOTS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ENTITY_SLOTS; i++) begin
                shadow[i] <= ENTITY_EMPTY;
                live[i] <= ENTITY_EMPTY;
            end
        end else begin
            // host side, always accepted
            if (wr_en && wr_slot < slot_t'(`ENTITY_SLOTS)) begin
                shadow[wr_slot] <= wr_entity;
            end
            // whole table swaps at once, sees the shadow from before this edge
            if (commit) begin
                live <= shadow;
            end
        end
    end

    assign live_1 = live[0];
    assign live_2 = live[1];
    assign live_3 = live[2];
    assign live_4 = live[3];
    assign live_5 = live[4];
    assign live_6 = live[5];
    assign live_7 = live[6];
    assign live_8 = live[7];
    assign live_9 = live[8];

endmodule

// File: verilog/entity_detector.sv
/* one cycle of latency on every output; slot 1 wins any overlap and the last two
   slots show their rows mirrored top to bottom */
`include "tts_cfg.svh"

module entity_detector import tts_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         active,
    input  logic         display_en,
    input  logic         hsync,
    input  logic         vsync,
    input  coord_t       h_count,
    input  coord_t       v_count,
    input  entity_t      live_1,
    input  entity_t      live_2,
    input  entity_t      live_3,
    input  entity_t      live_4,
    input  entity_t      live_5,
    input  entity_t      live_6,
    input  entity_t      live_7,
    input  entity_t      live_8,
    input  entity_t      live_9,
    output coord_t       pixel_x,
    output coord_t       pixel_y,
    output logic         hsync_out,
    output logic         vsync_out,
    output logic         de,
    output entity_code_t entity_code
);

    entity_t slots [`ENTITY_SLOTS];
    coord_t h_tile;
    coord_t v_tile;
    coord_t v_offset;
    logic [2:0] row;
    entity_code_t pick;
    logic de_next;

    // slot index 0 is entity 1
    assign slots[0] = live_1;
    assign slots[1] = live_2;
    assign slots[2] = live_3;
    assign slots[3] = live_4;
    assign slots[4] = live_5;
    assign slots[5] = live_6;
    assign slots[6] = live_7;
    assign slots[7] = live_8;
    assign slots[8] = live_9;

    // tiles sit on a fixed 40 pixel grid, so one tile index serves every slot
    assign h_tile = h_count / coord_t'(`TILE_LEN);
    assign v_tile = v_count / coord_t'(`TILE_LEN);
    assign v_offset = v_count % coord_t'(`TILE_LEN);
    // sprite row inside the tile, 0..7
    assign row = 3'(v_offset / coord_t'(`UPSCALE));

    // same as column*40 <= h < column*40+40 and likewise for the row
    function automatic logic slot_hit(entity_t ent, coord_t ht, coord_t vt);
        slot_hit = (ent[13:10] != `ID_UNUSED)
            && (ht == coord_t'(ent[3:0]))
            && (vt == coord_t'(ent[7:4]));
    endfunction

    // scan from the lowest priority up so slot 1 is written last
    always_comb begin
        logic [2:0] row_sel;
        pick = `CODE_NONE;
        for (int i = `ENTITY_SLOTS - 1; i >= 0; i--) begin
            // bit inversion gives 7 - row for the flipped slots
            row_sel = (i >= `FLIP_FIRST - 1) ? ~row : row;
            if (slot_hit(slots[i], h_tile, v_tile)) begin
                pick = {row_sel, slots[i][13:10], slots[i][9:8]};
            end
        end
    end

    // blanked area and the dark period after reset both show no entity
    assign de_next = active & display_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            pixel_x <= '0;
            pixel_y <= '0;
            hsync_out <= 1'b1;
            vsync_out <= 1'b1;
            de <= 1'b0;
            entity_code <= `CODE_NONE;
        end else begin
            // timing travels with the code so they stay aligned
            pixel_x <= h_count;
            pixel_y <= v_count;
            hsync_out <= hsync;
            vsync_out <= vsync;
            de <= de_next;
            entity_code <= de_next ? pick : `CODE_NONE;
        end
    end

endmodule

// File: verilog/tts_top.sv
/* clk is the pixel clock; host writes show up on screen only after the next
   vertical blank */
module tts_top import tts_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         wr_en,
    input  slot_t        wr_slot,
    input  entity_t      wr_entity,
    output coord_t       pixel_x,
    output coord_t       pixel_y,
    output logic         hsync_out,
    output logic         vsync_out,
    output logic         de,
    output entity_code_t entity_code
);

    // raster timing
    coord_t h_count;
    coord_t v_count;
    logic hsync;
    logic vsync;
    logic active;
    logic vblank_start;

    // frame control
    logic commit;
    logic display_en;

    // live table into the detector
    entity_t live_1;
    entity_t live_2;
    entity_t live_3;
    entity_t live_4;
    entity_t live_5;
    entity_t live_6;
    entity_t live_7;
    entity_t live_8;
    entity_t live_9;

    scan_timer u_timer (
        .clk          (clk),
        .rst          (rst),
        .h_count      (h_count),
        .v_count      (v_count),
        .hsync        (hsync),
        .vsync        (vsync),
        .active       (active),
        .vblank_start (vblank_start)
    );

    frame_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .vblank_start (vblank_start),
        .commit       (commit),
        .display_en   (display_en)
    );

    entity_table u_table (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .commit    (commit),
        .wr_slot   (wr_slot),
        .wr_entity (wr_entity),
        .live_1    (live_1),
        .live_2    (live_2),
        .live_3    (live_3),
        .live_4    (live_4),
        .live_5    (live_5),
        .live_6    (live_6),
        .live_7    (live_7),
        .live_8    (live_8),
        .live_9    (live_9)
    );

    entity_detector u_detector (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .display_en  (display_en),
        .hsync       (hsync),
        .vsync       (vsync),
        .h_count     (h_count),
        .v_count     (v_count),
        .live_1      (live_1),
        .live_2      (live_2),
        .live_3      (live_3),
        .live_4      (live_4),
        .live_5      (live_5),
        .live_6      (live_6),
        .live_7      (live_7),
        .live_8      (live_8),
        .live_9      (live_9),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .de          (de),
        .entity_code (entity_code)
    );

endmodule

// File: tb/tts_props.sv
/* checker sees only the top-level ports; the model copies its table on the edge that
   ends the output cycle showing pixel 0 of line 480, and drops writes to slots 9..15 */
`include "tts_cfg.svh"

module tts_props import tts_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         wr_en,
    input slot_t        wr_slot,
    input entity_t      wr_entity,
    input coord_t       pixel_x,
    input coord_t       pixel_y,
    input logic         hsync_out,
    input logic         vsync_out,
    input logic         de,
    input entity_code_t entity_code
);

    // inclusive sync windows of the raster
    localparam int HS_FIRST = `H_ACTIVE + `H_FRONT;
    localparam int HS_LAST = HS_FIRST + `H_SYNC - 1;
    localparam int VS_FIRST = `V_ACTIVE + `V_FRONT;
    localparam int VS_LAST = VS_FIRST + `V_SYNC - 1;
    localparam entity_t ENTITY_EMPTY = {`ID_UNUSED, 10'd0};

    // host view, committed view, and the view behind the current output pixel
    entity_t shadow [`ENTITY_SLOTS];
    entity_t live [`ENTITY_SLOTS];
    entity_t disp [`ENTITY_SLOTS];
    logic en_live;
    logic en_disp;
    // timer counts start at 0,0 after reset and reach the outputs a cycle later
    coord_t tim_x;
    coord_t tim_y;
    coord_t x_exp;
    coord_t y_exp;
    int fail_count = 0;

    logic hs_exp;
    logic vs_exp;
    logic de_exp;
    entity_code_t code_exp;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `ENTITY_SLOTS; i++) begin
                shadow[i] <= ENTITY_EMPTY;
                live[i] <= ENTITY_EMPTY;
                disp[i] <= ENTITY_EMPTY;
            end
            en_live <= 1'b0;
            en_disp <= 1'b0;
            tim_x <= '0;
            tim_y <= '0;
            x_exp <= '0;
            y_exp <= '0;
        end else begin
            if (wr_en && int'(wr_slot) < `ENTITY_SLOTS) begin
                shadow[wr_slot] <= wr_entity;
            end
            // a write on the commit edge stays in the shadow copy
            if (int'(pixel_x) == 0 && int'(pixel_y) == `V_ACTIVE) begin
                live <= shadow;
                en_live <= 1'b1;
            end
            // output lags the live table by one cycle
            disp <= live;
            en_disp <= en_live;
            x_exp <= tim_x;
            y_exp <= tim_y;
            // line wraps at 800 clocks and the frame at 525 lines
            if (int'(tim_x) == `H_TOTAL - 1) begin
                tim_x <= '0;
                tim_y <= (int'(tim_y) == `V_TOTAL - 1) ? '0 : coord_t'(int'(tim_y) + 1);
            end else begin
                tim_x <= coord_t'(int'(tim_x) + 1);
            end
        end
    end

    always_comb begin
        hs_exp = !(int'(pixel_x) >= HS_FIRST && int'(pixel_x) <= HS_LAST);
        vs_exp = !(int'(pixel_y) >= VS_FIRST && int'(pixel_y) <= VS_LAST);
    end

    // lowest slot whose 40x40 tile holds the pixel
    always_comb begin
        int left;
        int top;
        int sub_row;
        logic [2:0] row_bits;
        logic found;
        left = 0;
        top = 0;
        sub_row = 0;
        row_bits = '0;
        found = 1'b0;
        de_exp = en_disp && (int'(pixel_x) < `H_ACTIVE) && (int'(pixel_y) < `V_ACTIVE);
        code_exp = `CODE_NONE;
        for (int i = 0; i < `ENTITY_SLOTS; i++) begin
            left = int'(disp[i][3:0]) * `TILE_LEN;
            top = int'(disp[i][7:4]) * `TILE_LEN;
            if (de_exp && !found && disp[i][13:10] != `ID_UNUSED
                && int'(pixel_x) >= left && int'(pixel_x) < left + `TILE_LEN
                && int'(pixel_y) >= top && int'(pixel_y) < top + `TILE_LEN) begin
                sub_row = (int'(pixel_y) - top) / `UPSCALE;
                // slots 8 and 9 upside down
                if (i + 1 >= `FLIP_FIRST) begin
                    sub_row = 7 - sub_row;
                end
                row_bits = 3'(sub_row);
                code_exp = {row_bits, disp[i][13:10], disp[i][9:8]};
                found = 1'b1;
            end
        end
    end

    a_pixel_x: assert property (@(posedge clk) disable iff (rst) pixel_x == x_exp)
        else begin
            fail_count++;
            $error("FAIL pixel_x expected %0d actual %0d", $sampled(x_exp),
                $sampled(pixel_x));
        end

    a_pixel_y: assert property (@(posedge clk) disable iff (rst) pixel_y == y_exp)
        else begin
            fail_count++;
            $error("FAIL pixel_y expected %0d actual %0d", $sampled(y_exp),
                $sampled(pixel_y));
        end

    a_hsync: assert property (@(posedge clk) disable iff (rst) hsync_out == hs_exp)
        else begin
            fail_count++;
            $error("FAIL hsync expected %b actual %b", $sampled(hs_exp), $sampled(hsync_out));
        end

    a_vsync: assert property (@(posedge clk) disable iff (rst) vsync_out == vs_exp)
        else begin
            fail_count++;
            $error("FAIL vsync expected %b actual %b", $sampled(vs_exp), $sampled(vsync_out));
        end

    a_de: assert property (@(posedge clk) disable iff (rst) de == de_exp)
        else begin
            fail_count++;
            $error("FAIL de expected %b actual %b", $sampled(de_exp), $sampled(de));
        end

    // dark or blanked pixels carry no entity
    a_code_blank: assert property (@(posedge clk) disable iff (rst)
        !de_exp |-> (entity_code == `CODE_NONE))
        else begin
            fail_count++;
            $error("FAIL code_blank expected %h actual %h", `CODE_NONE, $sampled(entity_code));
        end

    a_code_entity: assert property (@(posedge clk) disable iff (rst)
        de_exp |-> (entity_code == code_exp))
        else begin
            fail_count++;
            $error("FAIL code_entity expected %h actual %h", $sampled(code_exp),
                $sampled(entity_code));
        end

endmodule

// File: tb/tts_tb.sv
/* four raster frames of host writes at a 10 unit pixel clock; checking is done by
   the bound tts_props module */
`include "tts_cfg.svh"

module tts_tb import tts_pkg::*; ();

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 10;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    // five frames leave one spare frame over the four the test needs
    localparam int WATCHDOG_TIME = (5 * FRAME_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic wr_en;
    slot_t wr_slot;
    entity_t wr_entity;
    coord_t pixel_x;
    coord_t pixel_y;
    logic hsync_out;
    logic vsync_out;
    logic de;
    entity_code_t entity_code;
    integer seed;
    logic run_ended;

    tts_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_entity   (wr_entity),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .de          (de),
        .entity_code (entity_code)
    );

    bind tts_top tts_props u_props (
        .clk         (clk),
        .rst         (rst),
        .wr_en       (wr_en),
        .wr_slot     (wr_slot),
        .wr_entity   (wr_entity),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .hsync_out   (hsync_out),
        .vsync_out   (vsync_out),
        .de          (de),
        .entity_code (entity_code)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic entity_t pack_entity(input logic [3:0] id, input logic [1:0] orient,
                                            input logic [3:0] row, input logic [3:0] col);
        return {id, orient, row, col};
    endfunction

    // returns 1 unit after the edge that puts x,y on the outputs
    task automatic wait_pixel(input coord_t x, input coord_t y);
        do begin
            @(posedge clk);
            #1;
        end while (pixel_x != x || pixel_y != y);
    endtask

    // called 1 unit after an edge and holds the strobe for one cycle
    task automatic host_write(input slot_t slot, input entity_t ent);
        wr_en = 1'b1;
        wr_slot = slot;
        wr_entity = ent;
        @(posedge clk);
        #1;
        wr_en = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        wr_en = 1'b0;
        wr_slot = '0;
        wr_entity = '0;
        seed = 63;
        run_ended = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // frame 1 runs dark while slots 0 and 1 share tile 2,1
        host_write(4'd0, pack_entity(4'd3, 2'd1, 4'd1, 4'd2));
        host_write(4'd1, pack_entity(4'd5, 2'd2, 4'd1, 4'd2));
        host_write(4'd2, pack_entity(4'd1, 2'd0, 4'd6, 4'd10));
        host_write(4'd4, pack_entity(`ID_UNUSED, 2'd3, 4'd4, 4'd4));
        // entity 8 alone and drawn flipped
        host_write(4'd7, pack_entity(4'd9, 2'd3, 4'd3, 4'd5));
        host_write(4'd8, pack_entity(4'd12, 2'd1, 4'd11, 4'd15));
        // out of range slot is dropped by the table
        host_write(4'd12, pack_entity(4'd2, 2'd0, 4'd0, 4'd0));
        wait_pixel('0, coord_t'(`V_ACTIVE));
        // frame 2 changes land mid-screen and wait for the next commit
        wait_pixel(coord_t'(`H_ACTIVE / 2), coord_t'(`V_ACTIVE / 2));
        host_write(4'd0, pack_entity(4'd6, 2'd0, 4'd7, 4'd7));
        host_write(4'd1, pack_entity(`ID_UNUSED, 2'd0, 4'd1, 4'd2));
        host_write(4'd4, pack_entity(4'd2, 2'd1, 4'd4, 4'd4));
        host_write(4'd7, pack_entity(4'd9, 2'd2, 4'd9, 4'd0));
        wait_pixel('0, coord_t'(`V_ACTIVE));
        // frame 3 gets random words in every slot and then a few at random slots
        wait_pixel('0, coord_t'(120));
        for (int i = 0; i < `ENTITY_SLOTS; i++) begin
            host_write(slot_t'(i), entity_t'($random(seed)));
        end
        repeat (4) begin
            host_write(slot_t'($random(seed)), entity_t'($random(seed)));
        end
        wait_pixel('0, coord_t'(`V_ACTIVE));
        // strobe sampled on the commit edge itself goes to the shadow only
        host_write(4'd3, pack_entity(4'd7, 2'd2, 4'd2, 4'd2));
        // frame 4 shows the random table
        wait_pixel('0, coord_t'(`V_ACTIVE));
        run_ended = 1'b1;
        if (u_dut.u_props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "%0d assertion failures during the run", u_dut.u_props.fail_count);
        end
    end

    initial begin
        wait (u_dut.u_props.fail_count != 0);
        run_ended = 1'b1;
        $display("TEST FAIL");
        $fatal(1, "an assertion in the bound checker failed");
    end

    // watchdog
    initial begin
        #(WATCHDOG_TIME);
        run_ended = 1'b1;
        $display("TEST FAIL");
        $fatal(1, "timeout, the raster never reached the end of frame four");
    end

    final begin
        if (!run_ended) begin
            $display("TEST FAIL");
            $fatal(1, "simulation stopped before the last frame was reached");
        end
    end

endmodule

// File: verilog.f
+incdir+verilog
verilog/tts_pkg.sv
verilog/scan_timer.sv
verilog/frame_ctrl.sv
verilog/entity_table.sv
verilog/entity_detector.sv
verilog/tts_top.sv
tb/tts_props.sv
tb/tts_tb.sv

// File: Makefile
# Verilator build of the sprite path testbench
VERILATOR ?= verilator
TOP       ?= tts_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: compile
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
